// File: common/ein_consts.svh
`ifndef EIN_CONSTS_SVH
`define EIN_CONSTS_SVH

// master-bus address this block answers to
`define EIN_BUS_ADDR 8'h65

// number of entries held by the frame buffer
`define EIN_FIFO_DEPTH 32

// first byte of every acknowledge frame
`define EIN_ACK_CODE 8'h06

// width of the runtime symbol-period divider
`define EIN_DIV_W 22

`endif

// File: common/ein_pkg.sv
`default_nettype none

package ein_pkg;

	// one beat of the chip-control master bus
	typedef struct packed {
		logic [7:0] addr;
		logic [7:0] data;
		logic       data_valid;
		logic       frame_valid;
	} ein_master_bus_t;

	// a buffered byte whose last bit marks the final byte of its frame
	typedef struct packed {
		logic       last;
		logic [7:0] data;
	} ein_fifo_word_t;

	// the header byte that opens each kept frame
	typedef struct packed {
		logic       fragment;
		logic [6:0] eid;
	} ein_header_t;

	// one beat of the outgoing acknowledge bus
	typedef struct packed {
		logic [7:0] data;
		logic       data_valid;
		logic       frame_valid;
	} ein_out_frame_t;

endpackage

`default_nettype wire

// File: hw/ein_frame_buffer.sv
`timescale 1ns/1ns
`default_nettype none
`include "ein_consts.svh"

module ein_frame_buffer (
	input  wire                          clk,
	input  wire                          reset,
	input  wire ein_pkg::ein_master_bus_t bus,
	input  wire                          hd_pop,
	input  wire                          mod_pop,
	output ein_pkg::ein_fifo_word_t      fifo_head,
	output logic                         fifo_empty,
	output logic                         overflow
);
	import ein_pkg::*;

	localparam int PTR_W = $clog2(`EIN_FIFO_DEPTH);

	ein_fifo_word_t mem [`EIN_FIFO_DEPTH];
	logic [PTR_W:0] wr_ptr;
	logic [PTR_W:0] rd_ptr;
	logic           pend_valid;
	logic [7:0]     pend_data;
	logic           accept;
	logic           wr_en;
	logic           wr_last;
	logic           fifo_full;
	logic           pop;

	assign accept = bus.data_valid && (bus.addr == `EIN_BUS_ADDR);

	// the pending byte is committed once we know whether it ends the frame
	// a following byte means more data, a dropped frame_valid means last
	assign wr_en = pend_valid && (accept || !bus.frame_valid);
	assign wr_last = !accept;

	// the extra pointer bit tells a full FIFO from an empty one
	assign fifo_full = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
		(wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
	assign fifo_empty = (wr_ptr == rd_ptr);

	// both consumers share one read port and never pop together
	assign pop = (hd_pop || mod_pop) && !fifo_empty;

	assign fifo_head = mem[rd_ptr[PTR_W-1:0]];

	always_ff @(posedge clk) begin
		if (reset) begin
			pend_valid <= 1'b0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			overflow <= 1'b0;
		end else begin
			overflow <= wr_en && fifo_full;
			if (accept) begin
				pend_valid <= 1'b1;
			end else if (wr_en) begin
				pend_valid <= 1'b0;
			end
			if (wr_en && !fifo_full) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			pend_data <= bus.data;
		end
		if (wr_en && !fifo_full) begin
			mem[wr_ptr[PTR_W-1:0]] <= '{last: wr_last, data: pend_data};
		end
	end

endmodule

`default_nettype wire

// File: hw/ein_header_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module ein_header_decoder (
	input  wire                         clk,
	input  wire                         reset,
	input  wire ein_pkg::ein_fifo_word_t fifo_head,
	input  wire                         fifo_empty,
	input  wire                         frame_sent,
	output logic                        hd_pop,
	output ein_pkg::ein_header_t        header,
	output logic                        header_done
);

	typedef enum logic {
		ST_IDLE,
		ST_BUSY
	} state_t;

	state_t state;

	// in idle the head of the FIFO is always the header of the next frame
	assign hd_pop = (state == ST_IDLE) && !fifo_empty;

	// header stays valid for the whole time the payload goes out
	assign header_done = (state == ST_BUSY);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (hd_pop) begin
						state <= ST_BUSY;
					end
				end
				ST_BUSY: begin
					// the modulator is done with this frame
					if (frame_sent) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// bit 7 flags a fragment and the low seven bits carry the event id
	always_ff @(posedge clk) begin
		if (hd_pop) begin
			header.fragment <= fifo_head.data[7];
			header.eid <= fifo_head.data[6:0];
		end
	end

endmodule

`default_nettype wire

// File: ein_mod/ein_modulator.sv
`timescale 1ns/1ns
`default_nettype none
`include "ein_consts.svh"

module ein_modulator (
	input  wire                         clk,
	input  wire                         reset,
	input  wire [`EIN_DIV_W-1:0]        clk_div,
	input  wire                         goc_mode,
	input  wire                         header_done,
	input  wire                         fragment,
	input  wire ein_pkg::ein_fifo_word_t fifo_head,
	input  wire                         fifo_empty,
	output logic                        mod_pop,
	output logic                        frame_sent,
	output logic                        emo_pad,
	output logic                        edi_pad,
	output logic                        eci_pad
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOAD,
		ST_BIT,
		ST_ECI,
		ST_TERM,
		ST_DONE
	} state_t;

	state_t                state;
	logic [`EIN_DIV_W-1:0] sym_cnt;
	logic                  sym_ready;
	logic                  sym_fire;
	logic [7:0]            shreg;
	logic [2:0]            bit_cnt;
	logic                  last_q;
	logic                  lsb_first;
	logic                  cur_bit;

	assign sym_ready = (sym_cnt == '0);
	assign sym_fire = sym_ready && (state == ST_BIT || state == ST_ECI || state == ST_TERM);
	assign mod_pop = (state == ST_LOAD) && header_done && !fifo_empty;
	assign frame_sent = (state == ST_DONE);
	assign cur_bit = lsb_first ? shreg[0] : shreg[7];

	// the timer reloads on every toggle, so toggles sit clk_div+1 cycles apart
	always_ff @(posedge clk) begin
		if (reset) begin
			sym_cnt <= '0;
		end else if (sym_fire) begin
			sym_cnt <= clk_div;
		end else if (!sym_ready) begin
			sym_cnt <= sym_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			bit_cnt <= '0;
			emo_pad <= 1'b0;
			edi_pad <= 1'b0;
			eci_pad <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: if (header_done) state <= ST_LOAD;
				// waits here while the FIFO runs dry in the middle of a frame
				ST_LOAD: begin
					if (mod_pop) begin
						bit_cnt <= '0;
						state <= ST_BIT;
					end
				end
				ST_BIT: begin
					if (sym_fire) begin
						if (cur_bit) begin
							emo_pad <= ~emo_pad;
						end else begin
							edi_pad <= ~edi_pad;
						end
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) begin
							state <= ST_ECI;
						end
					end
				end
				ST_ECI: begin
					if (sym_fire) begin
						eci_pad <= ~eci_pad;
						if (!last_q) begin
							state <= ST_LOAD;
						end else if (fragment) begin
							state <= ST_DONE;
						end else begin
							state <= ST_TERM;
						end
					end
				end
				ST_TERM: begin
					if (sym_fire) begin
						eci_pad <= ~eci_pad;
						state <= ST_DONE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// bit order is taken once per byte so it cannot change mid-byte
	always_ff @(posedge clk) begin
		if (mod_pop) begin
			shreg <= fifo_head.data;
			last_q <= fifo_head.last;
			lsb_first <= goc_mode;
		end else if (state == ST_BIT && sym_fire) begin
			shreg <= lsb_first ? (shreg >> 1) : (shreg << 1);
		end
	end

endmodule

`default_nettype wire

// File: hw/ein_ack_generator.sv
`timescale 1ns/1ns
`default_nettype none
`include "ein_consts.svh"

module ein_ack_generator (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    send_ack,
	input  wire [6:0]              eid,
	output ein_pkg::ein_out_frame_t ack_frame
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_CODE,
		ST_EID
	} state_t;

	state_t     state;
	logic [6:0] eid_q;

	// a trigger during an ongoing frame is simply not seen
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (send_ack) begin
						state <= ST_CODE;
					end
				end
				ST_CODE: state <= ST_EID;
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && send_ack) begin
			eid_q <= eid;
		end
	end

	always_comb begin
		ack_frame.frame_valid = (state != ST_IDLE);
		ack_frame.data_valid = (state != ST_IDLE);
		case (state)
			ST_CODE: ack_frame.data = `EIN_ACK_CODE;
			ST_EID:  ack_frame.data = {1'b0, eid_q};
			default: ack_frame.data = 8'h00;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/ein_int.sv
`timescale 1ns/1ns
`default_nettype none
`include "ein_consts.svh"

module ein_int (
	input  wire                          clk,
	input  wire                          reset,
	input  wire ein_pkg::ein_master_bus_t master_bus,
	input  wire                          goc_mode,
	input  wire [`EIN_DIV_W-1:0]         clk_div,
	output logic                         emo_pad,
	output logic                         edi_pad,
	output logic                         eci_pad,
	output logic                         overflow,
	output ein_pkg::ein_out_frame_t      ack_frame
);
	import ein_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_TX,
		ST_ACK
	} state_t;

	state_t         state;
	state_t         next_state;
	ein_fifo_word_t fifo_head;
	logic           fifo_empty;
	logic           hd_pop;
	logic           mod_pop;
	ein_header_t    header;
	logic           header_done;
	logic           frame_sent;
	logic           send_ack;
	logic [6:0]     ack_eid;

	ein_frame_buffer u_frame_buffer (
		.clk(clk), .reset(reset), .bus(master_bus), .hd_pop(hd_pop), .mod_pop(mod_pop),
		.fifo_head(fifo_head), .fifo_empty(fifo_empty), .overflow(overflow)
	);

	ein_header_decoder u_header_decoder (
		.clk(clk), .reset(reset), .fifo_head(fifo_head), .fifo_empty(fifo_empty),
		.frame_sent(frame_sent), .hd_pop(hd_pop), .header(header), .header_done(header_done)
	);

	ein_modulator u_modulator (
		.clk(clk), .reset(reset), .clk_div(clk_div), .goc_mode(goc_mode),
		.header_done(header_done), .fragment(header.fragment), .fifo_head(fifo_head),
		.fifo_empty(fifo_empty), .mod_pop(mod_pop), .frame_sent(frame_sent),
		.emo_pad(emo_pad), .edi_pad(edi_pad), .eci_pad(eci_pad)
	);

	ein_ack_generator u_ack_generator (
		.clk(clk), .reset(reset), .send_ack(send_ack), .eid(ack_eid), .ack_frame(ack_frame)
	);

	// the decoder may load the next header right after header_done falls,
	// so the id for the ack is kept from the frame that just went out
	always_ff @(posedge clk) begin
		if (header_done) begin
			ack_eid <= header.eid;
		end
	end

	always_comb begin
		next_state = state;
		send_ack = 1'b0;
		case (state)
			ST_IDLE: if (header_done) next_state = ST_TX;
			ST_TX:   if (!header_done) next_state = ST_ACK;
			ST_ACK: begin
				send_ack = 1'b1;
				next_state = ST_IDLE;
			end
			default: next_state = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			state <= next_state;
		end
	end

endmodule

`default_nettype wire

// File: tests/ein_tb_util.svh
`ifndef EIN_TB_UTIL_SVH
`define EIN_TB_UTIL_SVH

// codes for the pad that toggles in one symbol
localparam logic [1:0] PAD_EMO = 2'd0;
localparam logic [1:0] PAD_EDI = 2'd1;
localparam logic [1:0] PAD_ECI = 2'd2;

typedef logic [1:0] toggle_list_t[$];

// galois form of x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
	if (state[0]) begin
		return (state >> 1) ^ 16'hB400;
	end
	return state >> 1;
endfunction

task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
	if (got !== expected) begin
		fail_run($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, expected));
	end
endtask

// eight bit symbols per byte, then an ECI symbol, and one more ECI symbol
// closes a frame that is not a fragment
function automatic toggle_list_t expected_toggles(input logic [7:0] payload[$],
		input logic fragment, input logic lsb_first);
	toggle_list_t list;
	logic bit_value;
	foreach (payload[i]) begin
		for (int k = 0; k < 8; k++) begin
			bit_value = lsb_first ? payload[i][k] : payload[i][7 - k];
			list.push_back(bit_value ? PAD_EMO : PAD_EDI);
		end
		list.push_back(PAD_ECI);
	end
	if (!fragment) begin
		list.push_back(PAD_ECI);
	end
	return list;
endfunction

`endif

// File: tests/ein_int_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "ein_consts.svh"

module ein_int_tb;
	import ein_pkg::*;

	localparam int WAIT_LIMIT = 20000;

	logic                  clk;
	logic                  reset;
	ein_master_bus_t       master_bus;
	logic                  goc_mode;
	logic [`EIN_DIV_W-1:0] clk_div;
	logic                  emo_pad;
	logic                  edi_pad;
	logic                  eci_pad;
	logic                  overflow;
	ein_out_frame_t        ack_frame;

	logic [15:0] lfsr_state = 16'd40606;
	logic [1:0]  exp_pad_q[$];
	int          exp_gap_q[$];
	logic [6:0]  exp_eid_q[$];
	int          exp_end_q[$];
	logic [1:0]  obs_pad_q[$];
	int          obs_gap_q[$];
	logic [2:0]  prev_pads;
	logic        have_last = 1'b0;
	int          last_cycle = 0;
	int          cycle_count = 0;
	int          frames_sent = 0;
	int          acks_seen = 0;
	int          toggles_seen = 0;
	int          toggles_planned = 0;
	int          overflow_count = 0;
	int          ack_beat = 0;
	int          excess = 0;

	ein_int u_ein_int (
		.clk(clk), .reset(reset), .master_bus(master_bus), .goc_mode(goc_mode),
		.clk_div(clk_div), .emo_pad(emo_pad), .edi_pad(edi_pad), .eci_pad(eci_pad),
		.overflow(overflow), .ack_frame(ack_frame)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	`include "ein_tb_util.svh"

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	function automatic logic [7:0] foreign_addr();
		logic [7:0] addr;
		addr = rand_bits(8);
		if (addr == `EIN_BUS_ADDR) begin
			addr = addr ^ 8'h01;
		end
		return addr;
	endfunction

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) cycle_count <= cycle_count + 1;

	// pads change on the rising edge, so they are sampled on the falling one
	always @(negedge clk) begin : pad_monitor
		logic [2:0] cur;
		logic [1:0] code;
		cur = {eci_pad, edi_pad, emo_pad};
		if (reset) begin
			have_last = 1'b0;
		end else if (cur != prev_pads) begin
			case (cur ^ prev_pads)
				3'b001: code = PAD_EMO;
				3'b010: code = PAD_EDI;
				3'b100: code = PAD_ECI;
				default: fail_run("more than one pad toggled in the same cycle");
			endcase
			obs_pad_q.push_back(code);
			obs_gap_q.push_back(have_last ? cycle_count - last_cycle : 0);
			have_last = 1'b1;
			last_cycle = cycle_count;
			toggles_seen++;
		end
		prev_pads = cur;
	end

	// a zero expected gap marks the first toggle of a frame
	always @(posedge clk) begin : toggle_compare
		logic [1:0] got_pad;
		int got_gap;
		int want_gap;
		while (obs_pad_q.size() > 0) begin
			got_pad = obs_pad_q.pop_front();
			got_gap = obs_gap_q.pop_front();
			if (exp_pad_q.size() == 0) begin
				fail_run("a pad toggled while no toggle was expected");
			end
			want_gap = exp_gap_q.pop_front();
			check_value("pad_toggle", got_pad, exp_pad_q.pop_front());
			if (want_gap != 0) begin
				check_value("toggle_gap", got_gap, want_gap);
			end
		end
	end

	always @(negedge clk) begin : ack_monitor
		logic [6:0] eid;
		if (reset) begin
			ack_beat = 0;
		end else if (ack_frame.frame_valid) begin
			check_value("ack_frame.data_valid", ack_frame.data_valid, 1'b1);
			if (ack_beat == 0) begin
				if (exp_eid_q.size() == 0) begin
					fail_run("an ack frame came with no sent frame to answer");
				end
				// the last toggle of the answered frame comes before its ack
				if (toggles_seen < exp_end_q.pop_front()) begin
					fail_run("an ack frame came before its frame had finished");
				end
				check_value("ack_frame.data", ack_frame.data, `EIN_ACK_CODE);
			end else if (ack_beat == 1) begin
				eid = exp_eid_q.pop_front();
				check_value("ack_frame.data", ack_frame.data, {1'b0, eid});
				acks_seen++;
			end else begin
				fail_run("ack frame_valid stayed high longer than two cycles");
			end
			ack_beat++;
		end else begin
			check_value("ack_frame.data_valid", ack_frame.data_valid, 1'b0);
			if (ack_beat == 1) begin
				fail_run("ack frame ended after a single byte");
			end
			ack_beat = 0;
		end
	end

	always @(negedge clk) begin
		if (!reset && overflow) begin
			overflow_count++;
		end
	end

	task automatic bus_beat(input logic [7:0] addr, input logic [7:0] data,
			input logic data_valid, input logic frame_valid);
		@(posedge clk);
		#1;
		master_bus = '{addr: addr, data: data, data_valid: data_valid, frame_valid: frame_valid};
	endtask

	task automatic send_frame(input logic [6:0] eid, input logic fragment,
			input logic [7:0] payload[$]);
		toggle_list_t toggles;
		toggles = expected_toggles(payload, fragment, goc_mode);
		foreach (toggles[i]) begin
			exp_pad_q.push_back(toggles[i]);
			exp_gap_q.push_back(i == 0 ? 0 : int'(clk_div) + 1);
		end
		toggles_planned += toggles.size();
		exp_end_q.push_back(toggles_planned);
		exp_eid_q.push_back(eid);
		frames_sent++;
		// another block's frame ahead of this one
		if (rand_bits(1)) begin
			bus_beat(foreign_addr(), rand_bits(8), 1'b1, 1'b1);
			bus_beat(8'h00, 8'h00, 1'b0, 1'b0);
		end
		bus_beat(`EIN_BUS_ADDR, {fragment, eid}, 1'b1, 1'b1);
		foreach (payload[i]) begin
			if (rand_bits(2) == 0) begin
				bus_beat(foreign_addr(), rand_bits(8), 1'b1, 1'b1);
			end
			if (rand_bits(2) == 0) begin
				bus_beat(8'h00, 8'h00, 1'b0, 1'b1);
			end
			bus_beat(`EIN_BUS_ADDR, payload[i], 1'b1, 1'b1);
		end
		bus_beat(8'h00, 8'h00, 1'b0, 1'b0);
	endtask

	task automatic wait_for_acks(input int target);
		int waited;
		waited = 0;
		while (acks_seen < target) begin
			@(posedge clk);
			waited++;
			if (waited > WAIT_LIMIT) begin
				fail_run("timed out waiting for an ack frame");
			end
		end
	endtask

	task automatic wait_for_toggles(input int target);
		int waited;
		waited = 0;
		while (toggles_seen < target) begin
			@(posedge clk);
			waited++;
			if (waited > WAIT_LIMIT) begin
				fail_run("timed out waiting for a pad toggle");
			end
		end
	endtask

	task automatic check_idle();
		@(negedge clk);
		check_value("emo_pad", emo_pad, 1'b0);
		check_value("edi_pad", edi_pad, 1'b0);
		check_value("eci_pad", eci_pad, 1'b0);
		check_value("overflow", overflow, 1'b0);
		check_value("ack_frame.frame_valid", ack_frame.frame_valid, 1'b0);
		check_value("ack_frame.data_valid", ack_frame.data_valid, 1'b0);
	endtask

	task automatic run_phase(input int frames, input int div, input logic lsb_first,
			input logic fragment);
		logic [7:0] payload[$];
		int len;
		@(posedge clk);
		#1;
		clk_div = div;
		goc_mode = lsb_first;
		for (int f = 0; f < frames; f++) begin
			// at most two frames wait in the FIFO at any time
			wait_for_acks(frames_sent - 1);
			payload.delete();
			len = rand_bits(2) + 1;
			repeat (len) payload.push_back(rand_bits(8));
			send_frame(rand_bits(7), fragment, payload);
		end
		wait_for_acks(frames_sent);
		check_value("pending_toggles", exp_pad_q.size(), 0);
		check_value("overflow_count", overflow_count, 0);
	endtask

	task automatic overflow_burst();
		logic [7:0] payload[$];
		int burst;
		@(posedge clk);
		#1;
		clk_div = 200;
		goc_mode = 1'b0;
		payload.push_back(rand_bits(8));
		send_frame(7'h2a, 1'b0, payload);
		// once this frame toggles its header and payload have left the FIFO,
		// and nothing else is popped until its last symbol
		wait_for_toggles(toggles_seen + 1);
		burst = `EIN_FIFO_DEPTH + 8;
		excess = burst - `EIN_FIFO_DEPTH;
		for (int i = 0; i < burst; i++) begin
			bus_beat(`EIN_BUS_ADDR, rand_bits(8), 1'b1, 1'b1);
		end
		bus_beat(8'h00, 8'h00, 1'b0, 1'b0);
		repeat (4) @(posedge clk);
	endtask

	initial begin
		reset = 1'b1;
		master_bus = '0;
		goc_mode = 1'b0;
		clk_div = '0;
		repeat (16) @(posedge clk);
		#1 reset = 1'b0;
		check_idle();
		run_phase(6, 3, 1'b0, 1'b0);
		run_phase(4, 7, 1'b1, 1'b1);
		overflow_burst();
		// the burst frame lost its last byte and can never finish
		@(posedge clk);
		#1 reset = 1'b1;
		repeat (16) @(posedge clk);
		#1 reset = 1'b0;
		check_idle();
		// the small frame ahead of the burst never gets its ack
		if (acks_seen == frames_sent - 1 && overflow_count == excess) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			fail_run("ack or overflow totals are wrong at the end of the run");
		end
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+common
+incdir+tests
common/ein_pkg.sv
hw/ein_frame_buffer.sv
hw/ein_header_decoder.sv
ein_mod/ein_modulator.sv
hw/ein_ack_generator.sv
hw/ein_int.sv
tests/ein_int_tb.sv
